// File: build.f
+incdir+source
+incdir+dv
source/axil_ram_pkg.sv
source/ram_access_if.sv
source/single_port_blockram.sv
source/axil_ram_port.sv
source/axil_ram_top.sv
dv/axil_ram_tb.sv

// File: Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = axil_ram_tb
RTL_TOP    = axil_ram_top
FILELIST   = build.f
OBJ_DIR    = obj_dir
PASS_MSG   = NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Pass only if the pass line shows up in the run output.
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/axil_ram_tb_tasks.svh
`ifndef AXIL_RAM_TB_TASKS_SVH
`define AXIL_RAM_TB_TASKS_SVH

// ==============================
// Reference model.
// ==============================

logic [31:0] model_mem [256];
logic [3:0]  model_written [256];
logic [31:0] lfsr_state = 32'h06b916b8;

logic [1:0]  exp_bresp = 2'b00;
logic [1:0]  exp_rresp = 2'b00;
logic [31:0] exp_rdata = '0;
logic [31:0] exp_mask = '0;

function void clear_model();
    int i;
    for (i = 0; i < 256; i++)
        model_written[i] = 4'b0;
endfunction

// Taps 32, 22, 2, 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function logic [31:0] random_bits(input int count);
    logic [31:0] value;
    int i;
    value = '0;
    for (i = 0; i < count; i++)
    begin
        lfsr_state = lfsr_step(lfsr_state);
        value = {value[30:0], lfsr_state[0]};
    end
    return value;
endfunction

function automatic logic [31:0] lane_mask(input logic [3:0] lanes);
    logic [31:0] mask;
    int lane;
    for (lane = 0; lane < 4; lane++)
        mask[lane * 8 +: 8] = {8{lanes[lane]}};
    return mask;
endfunction

// Merged lane by lane; an out of range address leaves the model alone.
function void model_write(input logic [11:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    int lane;
    if (addr[11:10] != 2'b00)
        return;
    for (lane = 0; lane < 4; lane++)
    begin
        if (strb[lane])
            model_mem[addr[9:2]][lane * 8 +: 8] = data[lane * 8 +: 8];
    end
    model_written[addr[9:2]] = model_written[addr[9:2]] | strb;
endfunction

// ==============================
// Bus tasks.
// ==============================

task automatic write_word(input logic [11:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    int stall;
    @(negedge clk_in);
    awaddr    = addr;
    awvalid   = 1'b1;
    wdata     = data;
    wstrb     = strb;
    wvalid    = 1'b1;
    exp_bresp = (addr[11:10] != 2'b00) ? DECERR : OKAY;
    #1;
    while (!(awready && wready))
    begin
        @(negedge clk_in);
        #1;
    end
    model_write(addr, data, strb);
    @(negedge clk_in);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid)
        @(negedge clk_in);
    stall = random_bits(3);
    repeat (stall) @(negedge clk_in);
    bready = 1'b1;
    @(negedge clk_in);
    bready = 1'b0;
endtask

task automatic read_word(input logic [11:0] addr);
    int stall;
    @(negedge clk_in);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready)
    begin
        @(negedge clk_in);
        #1;
    end
    // Expected response follows the model as it stands at acceptance.
    exp_rdata = model_mem[addr[9:2]];
    exp_mask  = '0;
    if (addr[11:10] != 2'b00)
        exp_rresp = DECERR;
    else if (model_written[addr[9:2]] != 4'b0)
    begin
        exp_rresp = OKAY;
        exp_mask  = lane_mask(model_written[addr[9:2]]);
    end
    else
        exp_rresp = SLVERR;
    @(negedge clk_in);
    arvalid = 1'b0;
    while (!rvalid)
        @(negedge clk_in);
    stall = random_bits(3);
    repeat (stall) @(negedge clk_in);
    rready = 1'b1;
    @(negedge clk_in);
    rready = 1'b0;
endtask

// Small word window so that reads often hit earlier writes.
task automatic random_txn();
    logic [31:0] op;
    logic [31:0] pick;
    logic [31:0] hi;
    logic [31:0] word;
    logic [31:0] offs;
    logic [31:0] strb;
    logic [11:0] addr;
    op   = random_bits(1);
    pick = random_bits(3);
    hi   = random_bits(2);
    word = random_bits(4);
    offs = random_bits(2);
    strb = random_bits(4);
    if (pick[2:0] != 3'b000)
        hi = '0;
    addr = {hi[1:0], 4'h0, word[3:0], offs[1:0]};
    if (op[0])
        write_word(addr, random_bits(32), strb[3:0]);
    else
        read_word(addr);
endtask

task start_test();
    test_start_errors = error_count;
    test_count++;
endtask

task finish_test(input string name);
    if (error_count == test_start_errors)
        $display("Test %0d %s: passed", test_count, name);
    else
    begin
        $display("Test %0d %s: failed with %0d errors", test_count, name,
            error_count - test_start_errors);
        failed_tests++;
    end
endtask

`endif

// File: dv/axil_ram_tb.sv
`timescale 1ns/100ps
`default_nettype none

module axil_ram_tb;

    localparam int RESET_CYCLES = 16;
    localparam int TXN_COUNT    = 244;
    localparam int MAX_STALL    = 7;
    localparam int CYCLE_LIMIT  = 2 * RESET_CYCLES + TXN_COUNT * (MAX_STALL + 8);

    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;
    localparam logic [1:0] DECERR = 2'b11;

    logic        clk_in;
    logic        reset_in;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    int test_start_errors = 0;
    int cycle_count = 0;

    `include "axil_ram_tb_tasks.svh"

    axil_ram_top dut_i (.*);

    initial
    begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // ==============================
    // Protocol and data checks.
    // ==============================

    logic w_hs;
    logic ar_hs;

    assign w_hs  = awvalid && awready && wvalid && wready;
    assign ar_hs = arvalid && arready;

    assert property (@(posedge clk_in)
        reset_in |-> !(awready || wready || arready || bvalid || rvalid))
    else
    begin
        $display("%0t: a ready or valid output is high during reset", $time);
        error_count++;
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        bvalid && bready |-> bresp == exp_bresp)
    else
    begin
        $display("MISMATCH at %0t: bresp %0h, expected %0h", $time, $sampled(bresp), exp_bresp);
        error_count++;
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        rvalid && rready |-> rresp == exp_rresp && ((rdata ^ exp_rdata) & exp_mask) == 32'h0)
    else
    begin
        $display("MISMATCH at %0t: rresp %0h rdata %h, expected %0h %h", $time,
            $sampled(rresp), $sampled(rdata), exp_rresp, exp_rdata);
        error_count++;
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else
    begin
        $display("%0t: write response dropped or changed while stalled", $time);
        error_count++;
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else
    begin
        $display("%0t: read response dropped or changed while stalled", $time);
        error_count++;
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        $past(ar_hs, 2) |-> rvalid && !$past(rvalid))
    else
    begin
        $display("%0t: rvalid did not rise two cycles after the read request", $time);
        error_count++;
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        $past(w_hs) |-> bvalid && !$past(bvalid))
    else
    begin
        $display("%0t: bvalid did not rise one cycle after the write request", $time);
        error_count++;
    end

    // Write wins when both are pending.
    assert property (@(posedge clk_in) disable iff (reset_in)
        arvalid && awvalid && wvalid |-> !arready)
    else
    begin
        $display("%0t: read accepted ahead of a pending write", $time);
        error_count++;
    end

    always @(posedge clk_in)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, a handshake never completed", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ==============================
    // Test sequence.
    // ==============================

    initial
    begin
        int i;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        reset_in = 1'b1;
        clear_model();
        repeat (RESET_CYCLES) @(negedge clk_in);
        reset_in = 1'b0;

        start_test();
        for (i = 0; i < 8; i++)
            read_word(12'(i * 100));
        finish_test("reads after reset");

        start_test();
        for (i = 0; i < 8; i++)
        begin
            write_word(12'(64 + i * 4), random_bits(32), 4'hf);
            read_word(12'(64 + i * 4));
        end
        finish_test("full word write and read");

        start_test();
        write_word(12'h200, 32'h11223344, 4'hf);
        write_word(12'h200, 32'haabbccdd, 4'b0101);
        read_word(12'h200);
        write_word(12'h201, 32'h55667788, 4'b1000);
        read_word(12'h200);
        write_word(12'h300, 32'hdeadbeef, 4'b0000);
        read_word(12'h300);
        write_word(12'h200, 32'hffffffff, 4'b0000);
        read_word(12'h200);
        finish_test("partial and empty strobes");

        start_test();
        write_word(12'h040, 32'h0badf00d, 4'hf);
        write_word(12'h440, 32'h12345678, 4'hf);
        write_word(12'hc40, 32'h87654321, 4'hf);
        read_word(12'h840);
        read_word(12'h040);
        finish_test("out of range addresses");

        start_test();
        for (i = 0; i < 200; i++)
            random_txn();
        finish_test("random traffic with stalls");

        start_test();
        fork
            write_word(12'h0f0, 32'hc001d00d, 4'hf);
            read_word(12'h0f0);
        join
        finish_test("simultaneous write and read");

        // Reset lands while a write response is still pending.
        start_test();
        write_word(12'h010, 32'h5a5aa5a5, 4'hf);
        @(negedge clk_in);
        awaddr  = 12'h014;
        wdata   = 32'h3c3cc3c3;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!(awready && wready))
        begin
            @(negedge clk_in);
            #1;
        end
        @(negedge clk_in);
        awvalid  = 1'b0;
        wvalid   = 1'b0;
        reset_in = 1'b1;
        clear_model();
        repeat (RESET_CYCLES) @(negedge clk_in);
        reset_in = 1'b0;
        read_word(12'h010);
        read_word(12'h014);
        finish_test("reset clears responses and written words");

        $display("Tests: %0d, failed: %0d, errors: %0d", test_count, failed_tests, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/axil_ram_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "axil_ram_cfg.svh"

module axil_ram_top import axil_ram_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset_in,

    input  axil_addr_t  awaddr,
    input  logic        awvalid,
    output logic        awready,

    input  word_t       wdata,
    input  strb_t       wstrb,
    input  logic        wvalid,
    output logic        wready,

    output resp_t       bresp,
    output logic        bvalid,
    input  logic        bready,

    input  axil_addr_t  araddr,
    input  logic        arvalid,
    output logic        arready,

    output word_t       rdata,
    output resp_t       rresp,
    output logic        rvalid,
    input  logic        rready
);

    ram_access_if ram_bus ();

    axil_ram_port port_i
    (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .ram      (ram_bus.controller)
    );

    // Valid array on, so unwritten words read back as SLVERR.
    single_port_blockram
    #(
        .SINGLE_ENTRY_SIZE_IN_BITS (`RAM_DATA_WIDTH),
        .NUM_SET                   (`RAM_NUM_SET),
        .WITH_VALID_REG_ARRAY      ("Yes")
    )
    ram_i
    (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .mem      (ram_bus.memory)
    );

endmodule

`default_nettype wire

// File: source/axil_ram_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "axil_ram_cfg.svh"

module axil_ram_port import axil_ram_pkg::*;
(
    input  logic                    clk_in,
    input  logic                    reset_in,

    // AW channel.
    input  axil_addr_t              awaddr,
    input  logic                    awvalid,
    output logic                    awready,

    // W channel.
    input  word_t                   wdata,
    input  strb_t                   wstrb,
    input  logic                    wvalid,
    output logic                    wready,

    // B channel.
    output resp_t                   bresp,
    output logic                    bvalid,
    input  logic                    bready,

    // AR channel.
    input  axil_addr_t              araddr,
    input  logic                    arvalid,
    output logic                    arready,

    // R channel.
    output word_t                   rdata,
    output resp_t                   rresp,
    output logic                    rvalid,
    input  logic                    rready,

    ram_access_if.controller        ram
);

    // Byte offset bits below the word index, then the word index itself.
    localparam ADDR_LSB = $clog2(`RAM_DATA_WIDTH / `BYTE_LEN_IN_BITS);
    localparam SET_BITS = $clog2(`RAM_NUM_SET);
    localparam SET_TOP  = ADDR_LSB + SET_BITS;

    port_state_t state;

    logic write_go;
    logic read_go;
    logic aw_out_of_range;
    logic ar_out_of_range;
    logic rd_out_of_range;

    // ==============================
    // Decode and arbitration.
    // ==============================

    assign aw_out_of_range = |awaddr[`AXIL_ADDR_WIDTH - 1 : SET_TOP];
    assign ar_out_of_range = |araddr[`AXIL_ADDR_WIDTH - 1 : SET_TOP];

    // Write has priority over a read pending in the same cycle.
    assign write_go = (state == IDLE) && awvalid && wvalid;
    assign read_go  = (state == IDLE) && !write_go && arvalid;

    assign awready = write_go;
    assign wready  = write_go;
    assign arready = read_go;

    // ==============================
    // RAM access.
    // ==============================

    always_comb
    begin
        ram.access_en   = (write_go && !aw_out_of_range) || (read_go && !ar_out_of_range);
        ram.write_entry = wdata;

        if (write_go)
        begin
            ram.write_en = wstrb;
            ram.set_addr = awaddr[ADDR_LSB +: SET_BITS];
        end
        else
        begin
            ram.write_en = '0;
            ram.set_addr = araddr[ADDR_LSB +: SET_BITS];
        end
    end

    // ==============================
    // Response FSM.
    // ==============================

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state           <= IDLE;
            bvalid          <= 1'b0;
            bresp           <= RESP_OKAY;
            rvalid          <= 1'b0;
            rresp           <= RESP_OKAY;
            rd_out_of_range <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (write_go)
                    begin
                        bvalid <= 1'b1;
                        bresp  <= aw_out_of_range ? RESP_DECERR : RESP_OKAY;
                        state  <= WRITE_RESP;
                    end
                    else if (read_go)
                    begin
                        rd_out_of_range <= ar_out_of_range;
                        state           <= READ_WAIT;
                    end
                end

                // RAM result for the accepted read is on the bus now.
                READ_WAIT:
                begin
                    if (rd_out_of_range)
                    begin
                        rresp <= RESP_DECERR;
                    end
                    else if (ram.read_valid)
                    begin
                        rresp <= RESP_OKAY;
                    end
                    else
                    begin
                        rresp <= RESP_SLVERR;
                    end
                    rvalid <= 1'b1;
                    state  <= READ_RESP;
                end

                READ_RESP:
                begin
                    if (rready)
                    begin
                        rvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end

                WRITE_RESP:
                begin
                    if (bready)
                    begin
                        bvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Read data capture.
    always_ff @(posedge clk_in)
    begin
        if (state == READ_WAIT)
        begin
            rdata <= rd_out_of_range ? '0 : ram.read_entry;
        end
    end

endmodule

`default_nettype wire

// File: source/single_port_blockram.sv
`timescale 1ns/100ps
`default_nettype none

`include "axil_ram_cfg.svh"

module single_port_blockram
#(
    parameter SINGLE_ENTRY_SIZE_IN_BITS = `RAM_DATA_WIDTH,
    parameter NUM_SET                   = `RAM_NUM_SET,
    parameter WITH_VALID_REG_ARRAY      = "Yes"
)
(
    input  logic            clk_in,
    input  logic            reset_in,
    ram_access_if.memory    mem
);

    localparam WRITE_MASK_LEN = SINGLE_ENTRY_SIZE_IN_BITS / `BYTE_LEN_IN_BITS;

    // ==============================
    // Valid tracking.
    // ==============================

    generate
        if (WITH_VALID_REG_ARRAY == "Yes")
        begin : gen_valid_array
            logic [NUM_SET - 1 : 0] valid_array;

            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    valid_array    <= '0;
                    mem.read_valid <= 1'b0;
                end
                else
                begin
                    // Any enabled lane marks the set as written.
                    if (mem.access_en && |mem.write_en)
                    begin
                        valid_array[mem.set_addr] <= 1'b1;
                    end

                    // Bit seen before this access's own write.
                    if (mem.access_en)
                    begin
                        mem.read_valid <= valid_array[mem.set_addr];
                    end
                    else
                    begin
                        mem.read_valid <= 1'b0;
                    end
                end
            end
        end
        else
        begin : gen_no_valid_array
            assign mem.read_valid = !reset_in;
        end
    endgenerate

    // ==============================
    // Storage.
    // ==============================

    logic [SINGLE_ENTRY_SIZE_IN_BITS - 1 : 0] blockram [NUM_SET];

    always_ff @(posedge clk_in)
    begin
        if (mem.access_en)
        begin
            for (int lane = 0; lane < WRITE_MASK_LEN; lane++)
            begin
                if (mem.write_en[lane])
                begin
                    blockram[mem.set_addr][lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS]
                        <= mem.write_entry[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
                end
            end

            // Old contents, read-before-write.
            mem.read_entry <= blockram[mem.set_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/ram_access_if.sv
`timescale 1ns/100ps
`default_nettype none

// One RAM access per cycle, results come back a cycle later.
interface ram_access_if import axil_ram_pkg::*; ();

    logic       access_en;
    strb_t      write_en;
    set_addr_t  set_addr;
    word_t      write_entry;

    word_t      read_entry;
    logic       read_valid;

    modport controller
    (
        output access_en,
        output write_en,
        output set_addr,
        output write_entry,
        input  read_entry,
        input  read_valid
    );

    modport memory
    (
        input  access_en,
        input  write_en,
        input  set_addr,
        input  write_entry,
        output read_entry,
        output read_valid
    );

endinterface

`default_nettype wire

// File: source/axil_ram_pkg.sv
`default_nettype none

`include "axil_ram_cfg.svh"

package axil_ram_pkg;

    typedef logic [`RAM_DATA_WIDTH - 1 : 0]                        word_t;
    typedef logic [`RAM_DATA_WIDTH / `BYTE_LEN_IN_BITS - 1 : 0]    strb_t;
    typedef logic [$clog2(`RAM_NUM_SET) - 1 : 0]                   set_addr_t;
    typedef logic [`AXIL_ADDR_WIDTH - 1 : 0]                       axil_addr_t;
    typedef logic [1 : 0]                                          resp_t;

    // AXI response codes.
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    typedef enum logic [1 : 0]
    {
        IDLE,
        READ_WAIT,
        READ_RESP,
        WRITE_RESP
    } port_state_t;

endpackage

`default_nettype wire

// File: source/axil_ram_cfg.svh
`ifndef AXIL_RAM_CFG_SVH
`define AXIL_RAM_CFG_SVH

// ==============================
// RAM geometry.
// ==============================

// Width of one stored word.
`define RAM_DATA_WIDTH 32

// Number of words held by the RAM.
`define RAM_NUM_SET 256

// Width of one write lane.
`define BYTE_LEN_IN_BITS 8

// AXI4-Lite byte address width.
`define AXIL_ADDR_WIDTH 12

`endif
